// ==== src/vga_text_pkg.sv ====
package vga_text_pkg;

    // Pixel counter width, enough for an 800x525 raster
    localparam int coord_w = 10;

    // Text buffer, one page
    localparam int text_addr_w = 13;                 // Index within a page
    localparam int text_depth  = 2 ** text_addr_w;   // 8192 cells cover 80x60

    // Font RAM, address is code*8 + glyph row
    localparam int font_addr_w = 11;
    localparam int font_depth  = 2 ** font_addr_w;

    localparam int char_w = 8;                       // Character code width

    localparam int apb_addr_w = 8;                   // APB byte address width

    // 24-bit colour, red in the top byte
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // APB register map
    typedef enum logic [apb_addr_w-1:0] {
        REG_CTRL      = 8'h00,  // Bit 0 display enable, bit 1 page shown
        REG_FG        = 8'h04,  // Foreground colour
        REG_BG        = 8'h08,  // Background colour
        REG_TEXT_ADDR = 8'h0C,  // Bit 13 page, bits 12..0 index
        REG_TEXT_DATA = 8'h10,  // Write only, auto-increment
        REG_FONT_ADDR = 8'h14,
        REG_FONT_DATA = 8'h18,  // Write only, auto-increment
        REG_FRAME_CNT = 8'h1C   // Read only
    } apb_reg_e;

endpackage

// ==== src/apb_text_regs.sv ====
`timescale 1ns/1ps

module apb_text_regs (
    input  logic                                  vgaclk,
    input  logic                                  rst_n,
    input  logic [vga_text_pkg::apb_addr_w-1:0]   paddr,
    input  logic                                  psel,
    input  logic                                  penable,
    input  logic                                  pwrite,
    input  logic [31:0]                           pwdata,
    output logic [31:0]                           prdata,
    output logic                                  pready,
    output logic                                  pslverr,
    input  logic                                  frame_start,
    output logic                                  disp_en,
    output logic                                  page_sel,
    output vga_text_pkg::rgb_t                    fg_color,
    output vga_text_pkg::rgb_t                    bg_color,
    output logic                                  text_we,
    output logic [vga_text_pkg::text_addr_w:0]    text_waddr,
    output logic [vga_text_pkg::char_w-1:0]       text_wdata,
    output logic                                  font_we,
    output logic [vga_text_pkg::font_addr_w-1:0]  font_waddr,
    output logic [7:0]                            font_wdata
);
    import vga_text_pkg::*;

    apb_reg_e               reg_addr;
    logic                   access;     // Access phase of a transfer
    logic                   addr_ok;    // Address hits the map
    logic                   wr_ok;      // Accepted write
    logic [31:0]            rdata;
    logic [text_addr_w:0]   text_ptr;   // Page bit plus index
    logic [font_addr_w-1:0] font_ptr;
    logic [15:0]            frame_cnt;

    assign reg_addr = apb_reg_e'(paddr);
    assign access   = psel & penable;
    assign pready   = 1'b1;             // Zero wait states

    // Address decode and read mux
    always_comb begin
        addr_ok = 1'b1;
        rdata   = '0;
        case (reg_addr)
            REG_CTRL:      rdata = {30'd0, page_sel, disp_en};
            REG_FG:        rdata = {8'd0, fg_color};
            REG_BG:        rdata = {8'd0, bg_color};
            REG_TEXT_ADDR: rdata = 32'(text_ptr);
            REG_FONT_ADDR: rdata = 32'(font_ptr);
            REG_TEXT_DATA,
            REG_FONT_DATA: rdata = '0;  // Data ports read back zero
            REG_FRAME_CNT: rdata = {16'd0, frame_cnt};
            default:       addr_ok = 1'b0;
        endcase
    end

    assign prdata  = rdata;
    assign pslverr = access & (~addr_ok | (pwrite & (reg_addr == REG_FRAME_CNT)));
    assign wr_ok   = access & pwrite & ~pslverr;

    // Control, colour and pointer registers
    always_ff @(posedge vgaclk or negedge rst_n) begin
        if (!rst_n) begin
            disp_en   <= 1'b0;
            page_sel  <= 1'b0;
            fg_color  <= '0;
            bg_color  <= '0;
            text_ptr  <= '0;
            font_ptr  <= '0;
            text_we   <= 1'b0;
            font_we   <= 1'b0;
            frame_cnt <= '0;
        end else begin
            text_we <= 1'b0;                        // Strobes last one cycle
            font_we <= 1'b0;
            if (frame_start)
                frame_cnt <= frame_cnt + 1'b1;
            if (wr_ok) begin
                case (reg_addr)
                    REG_CTRL: begin
                        disp_en  <= pwdata[0];
                        page_sel <= pwdata[1];
                    end
                    REG_FG:        fg_color <= pwdata[23:0];
                    REG_BG:        bg_color <= pwdata[23:0];
                    REG_TEXT_ADDR: text_ptr <= pwdata[text_addr_w:0];
                    REG_FONT_ADDR: font_ptr <= pwdata[font_addr_w-1:0];
                    REG_TEXT_DATA: begin
                        text_we  <= 1'b1;
                        // Index wraps inside the selected page
                        text_ptr <= {text_ptr[text_addr_w],
                                     text_ptr[text_addr_w-1:0] + 1'b1};
                    end
                    REG_FONT_DATA: begin
                        font_we  <= 1'b1;
                        font_ptr <= font_ptr + 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // Write payload, qualified by the strobes
    always_ff @(posedge vgaclk) begin
        if (wr_ok && reg_addr == REG_TEXT_DATA) begin
            text_waddr <= text_ptr;
            text_wdata <= pwdata[char_w-1:0];
        end
        if (wr_ok && reg_addr == REG_FONT_DATA) begin
            font_waddr <= font_ptr;
            font_wdata <= pwdata[7:0];
        end
    end

    // An error response only ends a transfer that had its setup cycle
    a_slverr_access: assert property (@(posedge vgaclk) disable iff (!rst_n)
        pslverr |-> psel && penable && $past(psel));

endmodule

// ==== src/vga_timing.sv ====
`timescale 1ns/1ps

module vga_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_FP     = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BP     = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FP     = 11,
    parameter int V_SYNC   = 2,
    parameter int V_BP     = 32
) (
    input  logic                              vgaclk,
    input  logic                              rst_n,
    output logic [vga_text_pkg::coord_w-1:0]  x,
    output logic [vga_text_pkg::coord_w-1:0]  y,
    output logic                              active,
    output logic                              hs,
    output logic                              vs,
    output logic                              frame_start
);
    import vga_text_pkg::*;

    localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam int HS_START = H_ACTIVE + H_FP;
    localparam int VS_START = V_ACTIVE + V_FP;

    logic [coord_w-1:0] hcnt;
    logic [coord_w-1:0] vcnt;
    logic [coord_w-1:0] h_next;
    logic [coord_w-1:0] v_next;
    logic               h_wrap;
    logic               v_wrap;
    logic               h_act;
    logic               v_act;

    // Next raster position
    always_comb begin
        h_wrap = (hcnt == coord_w'(H_TOTAL - 1));
        v_wrap = (vcnt == coord_w'(V_TOTAL - 1));
        h_next = h_wrap ? '0 : hcnt + 1'b1;
        if (h_wrap)
            v_next = v_wrap ? '0 : vcnt + 1'b1;    // Step a line at end of row
        else
            v_next = vcnt;
        h_act = (h_next < coord_w'(H_ACTIVE));
        v_act = (v_next < coord_w'(V_ACTIVE));
    end

    // Outputs are decoded from the next position so they line up with the counters
    always_ff @(posedge vgaclk or negedge rst_n) begin
        if (!rst_n) begin
            hcnt        <= coord_w'(H_TOTAL - 1);  // First tick lands on (0,0)
            vcnt        <= coord_w'(V_TOTAL - 1);
            x           <= '0;
            y           <= '0;
            active      <= 1'b0;
            hs          <= 1'b1;
            vs          <= 1'b1;
            frame_start <= 1'b0;
        end else begin
            hcnt        <= h_next;
            vcnt        <= v_next;
            x           <= h_act ? h_next : '0;    // Zero outside the active area
            y           <= v_act ? v_next : '0;
            active      <= h_act & v_act;
            hs          <= ~((h_next >= coord_w'(HS_START)) &&
                             (h_next <  coord_w'(HS_START + H_SYNC)));
            vs          <= ~((v_next >= coord_w'(VS_START)) &&
                             (v_next <  coord_w'(VS_START + V_SYNC)));
            frame_start <= h_wrap & v_wrap;
        end
    end

    a_cnt_range: assert property (@(posedge vgaclk) disable iff (!rst_n)
        (hcnt < coord_w'(H_TOTAL)) && (vcnt < coord_w'(V_TOTAL)));

endmodule

// ==== src/text_fetch.sv ====
`timescale 1ns/1ps

module text_fetch #(
    parameter int H_ACTIVE = 640
) (
    input  logic                                 vgaclk,
    input  logic                                 rst_n,
    input  logic [vga_text_pkg::coord_w-1:0]     x,
    input  logic [vga_text_pkg::coord_w-1:0]     y,
    input  logic                                 active,
    input  logic                                 hs,
    input  logic                                 vs,
    input  logic                                 page_sel,
    input  logic                                 text_we,
    input  logic [vga_text_pkg::text_addr_w:0]   text_waddr,
    input  logic [vga_text_pkg::char_w-1:0]      text_wdata,
    output logic [vga_text_pkg::char_w-1:0]      char_code,
    output logic [2:0]                           xoff,
    output logic [2:0]                           yoff,
    output logic                                 active_q,
    output logic                                 hs_q,
    output logic                                 vs_q
);
    import vga_text_pkg::*;

    localparam int COLS = H_ACTIVE / 8;     // Characters per text row

    logic [char_w-1:0]      text_ram [2*text_depth];   // Page 1 in the upper half
    logic [text_addr_w-1:0] col;
    logic [text_addr_w-1:0] row;
    logic [text_addr_w-1:0] char_idx;

    // Cell position from the pixel position
    assign col      = text_addr_w'(x[coord_w-1:3]);
    assign row      = text_addr_w'(y[coord_w-1:3]);
    assign char_idx = col + row * text_addr_w'(COLS);

    // Software write port
    always_ff @(posedge vgaclk) begin
        if (text_we)
            text_ram[text_waddr] <= text_wdata;
    end

    // Registered read, low position bits ride along
    always_ff @(posedge vgaclk) begin
        char_code <= text_ram[{page_sel, char_idx}];
        xoff      <= x[2:0];
        yoff      <= y[2:0];
    end

    always_ff @(posedge vgaclk or negedge rst_n) begin
        if (!rst_n) begin
            active_q <= 1'b0;
            hs_q     <= 1'b1;                // Syncs idle high
            vs_q     <= 1'b1;
        end else begin
            active_q <= active;
            hs_q     <= hs;
            vs_q     <= vs;
        end
    end

endmodule

// ==== src/glyph_fetch.sv ====
`timescale 1ns/1ps

module glyph_fetch (
    input  logic                                  vgaclk,
    input  logic                                  rst_n,
    input  logic [vga_text_pkg::char_w-1:0]       char_code,
    input  logic [2:0]                            xoff,
    input  logic [2:0]                            yoff,
    input  logic                                  active,
    input  logic                                  hs,
    input  logic                                  vs,
    input  logic                                  font_we,
    input  logic [vga_text_pkg::font_addr_w-1:0]  font_waddr,
    input  logic [7:0]                            font_wdata,
    output logic                                  pixel,
    output logic                                  active_q,
    output logic                                  hs_q,
    output logic                                  vs_q
);
    import vga_text_pkg::*;

    logic [7:0]             font_ram [font_depth];
    logic [font_addr_w-1:0] raddr;
    logic [7:0]             row_q;      // Glyph row of the current cell
    logic [2:0]             xoff_q;

    assign raddr = font_addr_w'({char_code, yoff});    // Code*8 + glyph row

    always_ff @(posedge vgaclk) begin
        if (font_we)
            font_ram[font_waddr] <= font_wdata;
    end

    always_ff @(posedge vgaclk) begin
        row_q  <= font_ram[raddr];
        xoff_q <= xoff;
    end

    // MSB is the leftmost pixel of the glyph
    assign pixel = row_q[3'd7 - xoff_q];

    always_ff @(posedge vgaclk or negedge rst_n) begin
        if (!rst_n) begin
            active_q <= 1'b0;
            hs_q     <= 1'b1;
            vs_q     <= 1'b1;
        end else begin
            active_q <= active;
            hs_q     <= hs;
            vs_q     <= vs;
        end
    end

    a_pixel_known: assert property (@(posedge vgaclk) disable iff (!rst_n)
        active_q |-> !$isunknown(pixel));

endmodule

// ==== src/pixel_out.sv ====
`timescale 1ns/1ps

module pixel_out (
    input  logic                vgaclk,
    input  logic                rst_n,
    input  logic                pixel,
    input  logic                active,
    input  logic                hs,
    input  logic                vs,
    input  logic                disp_en,
    input  vga_text_pkg::rgb_t  fg_color,
    input  vga_text_pkg::rgb_t  bg_color,
    output logic                hsync,
    output logic                vsync,
    output logic                blank_b,
    output logic [7:0]          red,
    output logic [7:0]          green,
    output logic [7:0]          blue
);
    import vga_text_pkg::*;

    rgb_t color_d;
    rgb_t color_q;

    // Black in blanking and while the display is off
    always_comb begin
        if (active && disp_en)
            color_d = pixel ? fg_color : bg_color;
        else
            color_d = '0;
    end

    always_ff @(posedge vgaclk or negedge rst_n) begin
        if (!rst_n) begin
            hsync   <= 1'b1;
            vsync   <= 1'b1;
            blank_b <= 1'b0;
            color_q <= '0;
        end else begin
            hsync   <= hs;
            vsync   <= vs;
            blank_b <= active;
            color_q <= color_d;
        end
    end

    assign red   = color_q.r;
    assign green = color_q.g;
    assign blue  = color_q.b;

endmodule

// ==== src/vga_text_top.sv ====
`timescale 1ns/1ps

module vga_text_top #(
    parameter int H_ACTIVE = 640,
    parameter int H_FP     = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BP     = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FP     = 11,
    parameter int V_SYNC   = 2,
    parameter int V_BP     = 32
) (
    input  logic                                vgaclk,
    input  logic                                rst_n,
    input  logic [vga_text_pkg::apb_addr_w-1:0] paddr,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [31:0]                         pwdata,
    output logic [31:0]                         prdata,
    output logic                                pready,
    output logic                                pslverr,
    output logic                                hsync,
    output logic                                vsync,
    output logic                                blank_b,
    output logic [7:0]                          red,
    output logic [7:0]                          green,
    output logic [7:0]                          blue
);
    import vga_text_pkg::*;

    // Register block to stages
    logic                   disp_en;
    logic                   page_sel;
    rgb_t                   fg_color;
    rgb_t                   bg_color;
    logic                   text_we;
    logic [text_addr_w:0]   text_waddr;
    logic [char_w-1:0]      text_wdata;
    logic                   font_we;
    logic [font_addr_w-1:0] font_waddr;
    logic [7:0]             font_wdata;
    logic                   frame_start;

    // Stage 0 to 1
    logic [coord_w-1:0] x0;
    logic [coord_w-1:0] y0;
    logic               act0;
    logic               hs0;
    logic               vs0;
    // Stage 1 to 2
    logic [char_w-1:0]  char_code1;
    logic [2:0]         xoff1;
    logic [2:0]         yoff1;
    logic               act1;
    logic               hs1;
    logic               vs1;
    // Stage 2 to 3
    logic               pix2;
    logic               act2;
    logic               hs2;
    logic               vs2;

    apb_text_regs regs0 (
        .vgaclk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr, .frame_start,
        .disp_en, .page_sel, .fg_color, .bg_color,
        .text_we, .text_waddr, .text_wdata,
        .font_we, .font_waddr, .font_wdata
    );

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) timing0 (
        .vgaclk, .rst_n, .x(x0), .y(y0), .active(act0), .hs(hs0), .vs(vs0),
        .frame_start
    );

    text_fetch #(.H_ACTIVE(H_ACTIVE)) text0 (
        .vgaclk, .rst_n, .x(x0), .y(y0), .active(act0), .hs(hs0), .vs(vs0),
        .page_sel, .text_we, .text_waddr, .text_wdata,
        .char_code(char_code1), .xoff(xoff1), .yoff(yoff1),
        .active_q(act1), .hs_q(hs1), .vs_q(vs1)
    );

    glyph_fetch glyph0 (
        .vgaclk, .rst_n, .char_code(char_code1), .xoff(xoff1), .yoff(yoff1),
        .active(act1), .hs(hs1), .vs(vs1),
        .font_we, .font_waddr, .font_wdata,
        .pixel(pix2), .active_q(act2), .hs_q(hs2), .vs_q(vs2)
    );

    pixel_out pix0 (
        .vgaclk, .rst_n, .pixel(pix2), .active(act2), .hs(hs2), .vs(vs2),
        .disp_en, .fg_color, .bg_color,
        .hsync, .vsync, .blank_b, .red, .green, .blue
    );

endmodule

// ==== sim/tb_vga_text.sv ====
`timescale 1ns/1ps

module tb_vga_text;
    import vga_text_pkg::*;

    // Small raster so a frame is only 1152 cycles
    localparam int H_ACT  = 32;
    localparam int H_FP   = 4;
    localparam int H_SYNC = 8;
    localparam int H_BP   = 4;
    localparam int V_ACT  = 16;
    localparam int V_FP   = 2;
    localparam int V_SYNC = 2;
    localparam int V_BP   = 4;
    localparam int LINE   = H_ACT + H_FP + H_SYNC + H_BP;    // 48 cycles
    localparam int COLS   = H_ACT / 8;                        // 4 x 2 grid
    localparam int CELLS  = COLS * (V_ACT / 8);
    localparam int MAX_CYCLES = 20000;

    logic                  vgaclk = 1'b0;
    logic                  rst_n;
    logic [apb_addr_w-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  hsync;
    logic                  vsync;
    logic                  blank_b;
    logic [7:0]            red;
    logic [7:0]            green;
    logic [7:0]            blue;

    // Model of what software has written
    logic [7:0] m_text [2][CELLS];
    logic [7:0] m_font [font_depth];
    rgb_t       m_fg;
    rgb_t       m_bg;
    logic       m_en;
    logic       m_page;

    int   seed = 83874;
    int   err_cnt = 0;           // Main process errors
    int   chk_errs = 0;          // Frame checker errors
    int   pass_cnt = 0;
    int   fail_cnt = 0;
    int   cycle_cnt = 0;
    int   vs_falls = 0;          // Falling vsync edges seen
    int   checked_pix = 0;
    logic check_en = 1'b0;       // Compare colours of the next frame

    // Checker state
    logic        vs_q = 1'b1;
    logic        bl_q = 1'b0;
    logic        in_frame = 1'b0;
    logic        chk_frame = 1'b0;
    int          line_cnt = 0;
    int          pix_cnt = 0;
    logic [23:0] exp_rgb;

    vga_text_top #(
        .H_ACTIVE(H_ACT), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_ACTIVE(V_ACT), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) dut0 (
        .vgaclk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr, .hsync, .vsync, .blank_b, .red, .green, .blue
    );

    always #4 vgaclk = ~vgaclk;    // 8 ns period

    // Expected colour of active pixel (col, row)
    function automatic logic [23:0] ref_pixel(input int col, input int row);
        int         idx;
        logic [7:0] code;
        logic [7:0] bits;
        if (!m_en)
            return 24'h0;
        idx  = col / 8 + (row / 8) * COLS;
        code = m_text[m_page][idx];
        bits = m_font[int'(code) * 8 + row % 8];
        return bits[7 - col % 8] ? m_fg : m_bg;      // MSB leftmost
    endfunction

    // Frame checker, frames run from one falling vsync edge to the next
    always @(posedge vgaclk) begin
        if (rst_n) begin
            if (vs_q && !vsync) begin
                if (in_frame && line_cnt != V_ACT) begin
                    $display("Frame had %0d active lines instead of %0d", line_cnt, V_ACT);
                    chk_errs++;
                end
                in_frame  = 1'b1;
                chk_frame = check_en;               // Armed for this frame
                line_cnt  = 0;
                vs_falls++;
            end
            if (blank_b) begin
                if (in_frame && chk_frame) begin
                    exp_rgb = ref_pixel(pix_cnt, line_cnt);
                    if ({red, green, blue} !== exp_rgb) begin
                        $display("** Error: rgb at (%0d,%0d) expected 0x%h actual 0x%h",
                                 pix_cnt, line_cnt, exp_rgb, {red, green, blue});
                        chk_errs++;
                    end
                    checked_pix++;
                end
                pix_cnt++;
            end else if (bl_q) begin                 // End of an active run
                if (in_frame && pix_cnt != H_ACT) begin
                    $display("Line %0d had %0d active cycles instead of %0d",
                             line_cnt, pix_cnt, H_ACT);
                    chk_errs++;
                end
                line_cnt++;
                pix_cnt = 0;
            end
            vs_q = vsync;
            bl_q = blank_b;
        end
    end

    // Run limit
    always @(posedge vgaclk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_cnt);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("** Error: %s expected 0x%h actual 0x%h", name, exp, act);
        err_cnt++;
    endtask

    // One zero-wait APB transfer, setup then access
    task automatic apb_transfer(input logic wr, input logic [7:0] addr,
                                input logic [31:0] wdata, input logic exp_err,
                                output logic [31:0] rdata);
        @(posedge vgaclk);
        paddr   <= addr;
        pwrite  <= wr;
        pwdata  <= wdata;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge vgaclk);
        penable <= 1'b1;
        @(posedge vgaclk);                            // Access cycle ends here
        rdata = prdata;
        if (pready !== 1'b1) begin
            $display("APB access to 0x%h did not complete in its access cycle", addr);
            err_cnt++;
        end
        if (pslverr !== exp_err)
            report_mismatch("pslverr", 32'(exp_err), 32'(pslverr));
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] unused;
        apb_transfer(1'b1, addr, data, exp_err, unused);
    endtask

    task automatic apb_read(input logic [7:0] addr, input logic exp_err,
                            output logic [31:0] data);
        apb_transfer(1'b0, addr, 32'h0, exp_err, data);
    endtask

    task automatic check_reg(input logic [7:0] addr, input string name,
                             input logic [31:0] exp);
        logic [31:0] rd;
        apb_read(addr, 1'b0, rd);
        if (rd !== exp)
            report_mismatch(name, exp, rd);
    endtask

    task automatic set_ctrl(input logic en, input logic page);
        apb_write(REG_CTRL, {30'd0, page, en}, 1'b0);
        m_en   = en;
        m_page = page;
    endtask

    // Random glyph rows for count codes starting at first
    task automatic load_font(input logic [7:0] first, input int count);
        logic [7:0] bits;
        apb_write(REG_FONT_ADDR, {21'd0, first, 3'd0}, 1'b0);
        for (int i = 0; i < count * 8; i++) begin
            bits = 8'($random(seed));
            m_font[int'(first) * 8 + i] = bits;
            apb_write(REG_FONT_DATA, {24'd0, bits}, 1'b0);
        end
    endtask

    // Copies the model page into the text RAM
    task automatic load_page(input int page);
        apb_write(REG_TEXT_ADDR, 32'(page) << text_addr_w, 1'b0);
        for (int i = 0; i < CELLS; i++)
            apb_write(REG_TEXT_DATA, {24'd0, m_text[page][i]}, 1'b0);
    endtask

    task automatic wait_falls(input int n);
        int target;
        @(negedge vgaclk);
        target = vs_falls + n;
        while (vs_falls < target)
            @(negedge vgaclk);
    endtask

    // hsync width and period, vsync width in cycles
    task automatic check_sync_geometry();
        int hs_low;
        int hs_per;
        int vs_low;
        @(negedge vgaclk);
        while (hsync !== 1'b1) @(negedge vgaclk);
        while (hsync !== 1'b0) @(negedge vgaclk);
        hs_low = 0;
        while (hsync === 1'b0) begin
            hs_low++;
            @(negedge vgaclk);
        end
        hs_per = hs_low;
        while (hsync === 1'b1) begin
            hs_per++;
            @(negedge vgaclk);
        end
        while (vsync !== 1'b1) @(negedge vgaclk);
        while (vsync !== 1'b0) @(negedge vgaclk);
        vs_low = 0;
        while (vsync === 1'b0) begin
            vs_low++;
            @(negedge vgaclk);
        end
        if (hs_low != H_SYNC)
            report_mismatch("hsync low cycles", 32'(H_SYNC), 32'(hs_low));
        if (hs_per != LINE)
            report_mismatch("hsync period", 32'(LINE), 32'(hs_per));
        if (vs_low != V_SYNC * LINE)
            report_mismatch("vsync low cycles", 32'(V_SYNC * LINE), 32'(vs_low));
    endtask

    task automatic start_test(output int errs);
        @(negedge vgaclk);
        errs = err_cnt + chk_errs;
    endtask

    task automatic end_test(input string name, input int errs_before);
        int errs;
        @(negedge vgaclk);
        errs = err_cnt + chk_errs - errs_before;
        if (errs == 0) begin
            pass_cnt++;
            $display("Test %s: pass", name);
        end else begin
            fail_cnt++;
            $display("Test %s: FAIL with %0d errors", name, errs);
        end
    endtask

    initial begin
        int          errs;
        int          pix0;
        logic [31:0] fc_a;
        logic [31:0] fc_b;
        rst_n   <= 1'b0;
        paddr   <= '0;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        pwdata  <= '0;
        m_en    = 1'b0;
        m_page  = 1'b0;
        m_fg    = 24'h0;
        m_bg    = 24'h0;
        repeat (5) @(posedge vgaclk);

        // 1: reset values, readback, error responses
        errs = err_cnt + chk_errs;
        if (hsync !== 1'b1)
            report_mismatch("hsync", 32'd1, 32'(hsync));
        if (vsync !== 1'b1)
            report_mismatch("vsync", 32'd1, 32'(vsync));
        if (blank_b !== 1'b0)
            report_mismatch("blank_b", 32'd0, 32'(blank_b));
        if ({red, green, blue} !== 24'h0)
            report_mismatch("rgb", 32'd0, 32'({red, green, blue}));
        rst_n <= 1'b1;
        apb_write(REG_FG, 32'h0012_3456, 1'b0);
        apb_write(REG_BG, 32'h00AB_CDEF, 1'b0);
        set_ctrl(1'b0, 1'b1);
        check_reg(REG_FG, "prdata REG_FG", 32'h0012_3456);
        check_reg(REG_BG, "prdata REG_BG", 32'h00AB_CDEF);
        check_reg(REG_CTRL, "prdata REG_CTRL", 32'h2);
        apb_write(8'h20, 32'hFFFF_FFFF, 1'b1);        // Unmapped
        apb_read(8'h20, 1'b1, fc_a);
        apb_write(REG_FRAME_CNT, 32'h0000_5A5A, 1'b1);  // Read only
        check_reg(REG_FG, "prdata REG_FG", 32'h0012_3456);
        check_reg(REG_BG, "prdata REG_BG", 32'h00AB_CDEF);
        check_reg(REG_CTRL, "prdata REG_CTRL", 32'h2);
        set_ctrl(1'b0, 1'b0);
        end_test("reset and registers", errs);

        // 2: sync geometry, line counts come from the checker
        start_test(errs);
        check_sync_geometry();
        wait_falls(2);
        end_test("sync geometry", errs);

        // 3: random glyphs for codes 0x30..0x37 on page 0
        start_test(errs);
        load_font(8'h30, 8);
        for (int i = 0; i < CELLS; i++)
            m_text[0][i] = 8'h30 + 8'($random(seed) & 7);
        load_page(0);
        apb_write(REG_FG, 32'h00F0_A050, 1'b0);
        m_fg = 24'hF0A050;
        apb_write(REG_BG, 32'h0010_2030, 1'b0);
        m_bg = 24'h102030;
        set_ctrl(1'b1, 1'b0);
        pix0 = checked_pix;
        check_en <= 1'b1;
        wait_falls(1);                                // Arms exactly one frame
        check_en <= 1'b0;
        wait_falls(1);
        if (checked_pix - pix0 != H_ACT * V_ACT) begin
            $display("Checker compared %0d pixels instead of %0d",
                     checked_pix - pix0, H_ACT * V_ACT);
            err_cnt++;
        end
        end_test("text rendering", errs);

        // 4: page 1 differs in every cell, switched in vertical blank
        start_test(errs);
        for (int i = 0; i < CELLS; i++)
            m_text[1][i] = m_text[0][i] ^ 8'h01;
        load_page(1);
        pix0 = checked_pix;
        check_en <= 1'b1;
        wait_falls(1);
        set_ctrl(1'b1, 1'b1);                         // Lands before line 0
        check_en <= 1'b0;
        wait_falls(1);
        if (checked_pix - pix0 != H_ACT * V_ACT) begin
            $display("Checker compared %0d pixels instead of %0d",
                     checked_pix - pix0, H_ACT * V_ACT);
            err_cnt++;
        end
        end_test("page switch", errs);

        // 5: display off, active area black
        start_test(errs);
        set_ctrl(1'b0, 1'b1);
        pix0 = checked_pix;
        check_en <= 1'b1;
        wait_falls(1);
        check_en <= 1'b0;
        wait_falls(1);
        if (checked_pix - pix0 != H_ACT * V_ACT) begin
            $display("Checker compared %0d pixels instead of %0d",
                     checked_pix - pix0, H_ACT * V_ACT);
            err_cnt++;
        end
        check_sync_geometry();
        end_test("display disable", errs);

        // 6: one frame_start per frame
        start_test(errs);
        wait_falls(1);
        apb_read(REG_FRAME_CNT, 1'b0, fc_a);
        wait_falls(3);
        apb_read(REG_FRAME_CNT, 1'b0, fc_b);
        if (fc_b - fc_a !== 32'd3)
            report_mismatch("REG_FRAME_CNT delta", 32'd3, fc_b - fc_a);
        end_test("frame counter", errs);

        $display("Tests passed %0d, failed %0d, errors %0d",
                 pass_cnt, fail_cnt, err_cnt + chk_errs);
        if (fail_cnt == 0 && err_cnt + chk_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
src/vga_text_pkg.sv
src/apb_text_regs.sv
src/vga_timing.sv
src/text_fetch.sv
src/glyph_fetch.sv
src/pixel_out.sv
src/vga_text_top.sv
sim/tb_vga_text.sv

// ==== Makefile ====
# Verilator build and run for the text-mode VGA subsystem

VERILATOR ?= verilator
TOP       ?= tb_vga_text
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TESTBENCH PASSED

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the output
run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
